//--- bus_pkg.sv
package bus_pkg;

  // arbiter states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_IF_DATA   = 3'd1,  // fetch issued, waiting for r
    ST_LS_ADDR   = 3'd2,
    ST_LS_DATA_R = 3'd3,
    ST_LS_DATA_W = 3'd4
  } bus_state_t;

  // machine timer words, answered locally
  localparam logic [31:0] RTC_ADDR    = 32'h0200_bff8;
  localparam logic [31:0] RTC_ADDR_UP = 32'h0200_bffc;

  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // axsize codes
  localparam logic [2:0] SIZE_BYTE = 3'd0;
  localparam logic [2:0] SIZE_HALF = 3'd1;
  localparam logic [2:0] SIZE_WORD = 3'd2;

endpackage

//--- core_timer.sv
`timescale 1ns/1ps

module core_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_en_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [63:0]       mtime_q;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 64'd1;
      rvalid_q <= rd_en_i;  // one cycle read latency
    end
  end

  // read data register, addr bit 2 picks the upper word
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      rdata_q <= rd_addr_i[2] ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

//--- lane_mapper.sv
`timescale 1ns/1ps

module lane_mapper #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic [ADDR_W-1:0]              ar_addr_i,
  input  logic [ADDR_W-1:0]              aw_addr_i,
  input  logic [7:0]                     rstrb_i,
  input  logic [7:0]                     wstrb_i,
  input  logic [DATA_W-1:0]              wdata_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0] axi_rdata_i,
  output logic [2:0]                     arsize_o,
  output logic [2:0]                     awsize_o,
  output logic [bus_pkg::AXI_DATA_W-1:0] axi_wdata_o,
  output logic [bus_pkg::AXI_STRB_W-1:0] axi_wstrb_o,
  output logic [DATA_W-1:0]              rdata_o
);

  import bus_pkg::*;

  localparam int HALF_STRB = AXI_STRB_W / 2;

  logic [DATA_W-1:0]    wdata_shift;
  logic [HALF_STRB-1:0] wstrb_shift;
  logic [DATA_W-1:0]    rdata_half;

  // strobe pattern to axsize, anything odd falls back to byte
  function automatic logic [2:0] strb_to_size(input logic [7:0] strb);
    logic [2:0] size;
    case (strb)
      8'h01:   size = SIZE_BYTE;
      8'h03:   size = SIZE_HALF;
      8'h0f:   size = SIZE_WORD;
      default: size = SIZE_BYTE;
    endcase
    return size;
  endfunction

  assign arsize_o = strb_to_size(rstrb_i);
  assign awsize_o = strb_to_size(wstrb_i);

  // write side
  always_comb
  begin
    wdata_shift = wdata_i << {aw_addr_i[1:0], 3'b000};
    wstrb_shift = wstrb_i[HALF_STRB-1:0] << aw_addr_i[1:0];
  end

  assign axi_wdata_o = {wdata_shift, wdata_shift};  // same word on both halves

  always_comb
  begin
    if (aw_addr_i[2])
    begin
      axi_wstrb_o = {wstrb_shift, {HALF_STRB{1'b0}}};
    end
    else
    begin
      axi_wstrb_o = {{HALF_STRB{1'b0}}, wstrb_shift};
    end
  end

  // read side, pick the half then right-align
  always_comb
  begin
    rdata_half = ar_addr_i[2] ? axi_rdata_i[DATA_W +: DATA_W] : axi_rdata_i[0 +: DATA_W];
    rdata_o    = rdata_half >> {ar_addr_i[1:0], 3'b000};
  end

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_arvalid_i,
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic              lsu_awvalid_i,
  input  logic              lsu_wvalid_i,
  input  logic              io_master_arready_i,
  input  logic              io_master_rvalid_i,
  input  logic              io_master_awready_i,
  input  logic              io_master_wready_i,
  input  logic              io_master_bvalid_i,
  input  logic              tm_rvalid_i,
  output logic              io_master_arvalid_o,
  output logic              io_master_awvalid_o,
  output logic              io_master_wvalid_o,
  output logic              io_master_wlast_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  output logic              tm_rd_en_o,
  output logic              ifu_rvalid_o,
  output logic              lsu_rvalid_o,
  output logic              lsu_wready_o
);

  import bus_pkg::*;

  localparam logic [ADDR_W-1:0] TM_LO = RTC_ADDR;
  localparam logic [ADDR_W-1:0] TM_HI = RTC_ADDR_UP;

  bus_state_t state_q;
  logic       ar_valid_q;
  logic       w_valid_q;

  logic ls_timer;
  logic store_req;
  logic ar_hs;
  logic aw_hs;
  logic w_hs;

  assign ls_timer  = (lsu_araddr_i == TM_LO) || (lsu_araddr_i == TM_HI);
  assign store_req = lsu_awvalid_i & lsu_wvalid_i;

  assign ar_hs = ar_valid_q & io_master_arready_i;
  assign aw_hs = io_master_awvalid_o & io_master_awready_i;
  assign w_hs  = w_valid_q & io_master_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= ST_IDLE;
      ar_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          // load/store first, fetch only when lsu is quiet
          if (lsu_arvalid_i)
          begin
            state_q    <= ST_LS_ADDR;
            ar_valid_q <= !ls_timer;
          end
          else if (store_req)
          begin
            state_q <= ST_LS_ADDR;
          end
          else if (ifu_arvalid_i)
          begin
            state_q    <= ST_IF_DATA;
            ar_valid_q <= 1'b1;
          end
        end
        ST_IF_DATA:
        begin
          if (ar_hs)
          begin
            ar_valid_q <= 1'b0;
          end
          if (io_master_rvalid_i)
          begin
            state_q <= ST_IDLE;
          end
        end
        ST_LS_ADDR:
        begin
          if (lsu_arvalid_i)
          begin
            if (ls_timer)
            begin
              state_q <= ST_LS_DATA_R;  // timer read issued this cycle
            end
            else if (ar_hs)
            begin
              state_q    <= ST_LS_DATA_R;
              ar_valid_q <= 1'b0;
            end
          end
          else if (aw_hs)
          begin
            state_q   <= ST_LS_DATA_W;
            w_valid_q <= 1'b1;
          end
        end
        ST_LS_DATA_R:
        begin
          if (io_master_rvalid_i | tm_rvalid_i)
          begin
            state_q <= ST_IDLE;
          end
        end
        ST_LS_DATA_W:
        begin
          if (w_hs)
          begin
            w_valid_q <= 1'b0;  // b may still be pending
          end
          if (io_master_bvalid_i)
          begin
            state_q <= ST_IDLE;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign io_master_arvalid_o = ar_valid_q;
  assign io_master_awvalid_o = (state_q == ST_LS_ADDR) & !lsu_arvalid_i & store_req;
  assign io_master_wvalid_o  = w_valid_q;
  assign io_master_wlast_o   = w_valid_q;  // single beat

  assign ar_addr_o  = (state_q == ST_IF_DATA) ? ifu_araddr_i : lsu_araddr_i;
  assign tm_rd_en_o = (state_q == ST_LS_ADDR) & lsu_arvalid_i & ls_timer;

  // completions go to whoever owns the current state
  assign ifu_rvalid_o = (state_q == ST_IF_DATA) & io_master_rvalid_i;
  assign lsu_rvalid_o = (state_q == ST_LS_DATA_R) & (io_master_rvalid_i | tm_rvalid_i);
  assign lsu_wready_o = (state_q == ST_LS_DATA_W) & io_master_bvalid_i;

endmodule

//--- mem_bus_top.sv
`timescale 1ns/1ps

module mem_bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                           clk,
  input  logic                           rst,
  // fetch unit
  input  logic                           ifu_arvalid_i,
  input  logic [ADDR_W-1:0]              ifu_araddr_i,
  output logic                           ifu_rvalid_o,
  output logic [DATA_W-1:0]              ifu_rdata_o,
  // load/store unit
  input  logic                           lsu_arvalid_i,
  input  logic [ADDR_W-1:0]              lsu_araddr_i,
  input  logic [7:0]                     lsu_rstrb_i,
  output logic                           lsu_rvalid_o,
  output logic [DATA_W-1:0]              lsu_rdata_o,
  input  logic                           lsu_awvalid_i,
  input  logic                           lsu_wvalid_i,
  input  logic [ADDR_W-1:0]              lsu_awaddr_i,
  input  logic [DATA_W-1:0]              lsu_wdata_i,
  input  logic [7:0]                     lsu_wstrb_i,
  output logic                           lsu_wready_o,
  // axi4 master
  output logic [1:0]                     io_master_arburst_o,
  output logic [2:0]                     io_master_arsize_o,
  output logic [7:0]                     io_master_arlen_o,
  output logic [3:0]                     io_master_arid_o,
  output logic [ADDR_W-1:0]              io_master_araddr_o,
  output logic                           io_master_arvalid_o,
  input  logic                           io_master_arready_i,
  input  logic [3:0]                     io_master_rid_i,
  input  logic                           io_master_rlast_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0] io_master_rdata_i,
  input  logic [1:0]                     io_master_rresp_i,
  input  logic                           io_master_rvalid_i,
  output logic                           io_master_rready_o,
  output logic [1:0]                     io_master_awburst_o,
  output logic [2:0]                     io_master_awsize_o,
  output logic [7:0]                     io_master_awlen_o,
  output logic [3:0]                     io_master_awid_o,
  output logic [ADDR_W-1:0]              io_master_awaddr_o,
  output logic                           io_master_awvalid_o,
  input  logic                           io_master_awready_i,
  output logic                           io_master_wlast_o,
  output logic [bus_pkg::AXI_DATA_W-1:0] io_master_wdata_o,
  output logic [bus_pkg::AXI_STRB_W-1:0] io_master_wstrb_o,
  output logic                           io_master_wvalid_o,
  input  logic                           io_master_wready_i,
  input  logic [3:0]                     io_master_bid_i,
  input  logic [1:0]                     io_master_bresp_i,
  input  logic                           io_master_bvalid_i,
  output logic                           io_master_bready_o
);

  logic [ADDR_W-1:0] ar_addr;
  logic              tm_rd_en;
  logic [DATA_W-1:0] tm_rdata;
  logic              tm_rvalid;
  logic [DATA_W-1:0] map_rdata;

  // single beat incr, id 0
  assign io_master_arburst_o = 2'b01;
  assign io_master_arlen_o   = 8'd0;
  assign io_master_arid_o    = 4'd0;
  assign io_master_awburst_o = 2'b01;
  assign io_master_awlen_o   = 8'd0;
  assign io_master_awid_o    = 4'd0;
  assign io_master_rready_o  = 1'b1;
  assign io_master_bready_o  = 1'b1;

  assign io_master_araddr_o = ar_addr;
  assign io_master_awaddr_o = lsu_awaddr_i;

  bus_arbiter #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_arbiter (
    .clk                 (clk),
    .rst                 (rst),
    .ifu_arvalid_i       (ifu_arvalid_i),
    .ifu_araddr_i        (ifu_araddr_i),
    .lsu_arvalid_i       (lsu_arvalid_i),
    .lsu_araddr_i        (lsu_araddr_i),
    .lsu_awvalid_i       (lsu_awvalid_i),
    .lsu_wvalid_i        (lsu_wvalid_i),
    .io_master_arready_i (io_master_arready_i),
    .io_master_rvalid_i  (io_master_rvalid_i),
    .io_master_awready_i (io_master_awready_i),
    .io_master_wready_i  (io_master_wready_i),
    .io_master_bvalid_i  (io_master_bvalid_i),
    .tm_rvalid_i         (tm_rvalid),
    .io_master_arvalid_o (io_master_arvalid_o),
    .io_master_awvalid_o (io_master_awvalid_o),
    .io_master_wvalid_o  (io_master_wvalid_o),
    .io_master_wlast_o   (io_master_wlast_o),
    .ar_addr_o           (ar_addr),
    .tm_rd_en_o          (tm_rd_en),
    .ifu_rvalid_o        (ifu_rvalid_o),
    .lsu_rvalid_o        (lsu_rvalid_o),
    .lsu_wready_o        (lsu_wready_o)
  );

  lane_mapper #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_lane_mapper (
    .ar_addr_i   (ar_addr),
    .aw_addr_i   (lsu_awaddr_i),
    .rstrb_i     (lsu_rstrb_i),
    .wstrb_i     (lsu_wstrb_i),
    .wdata_i     (lsu_wdata_i),
    .axi_rdata_i (io_master_rdata_i),
    .arsize_o    (io_master_arsize_o),
    .awsize_o    (io_master_awsize_o),
    .axi_wdata_o (io_master_wdata_o),
    .axi_wstrb_o (io_master_wstrb_o),
    .rdata_o     (map_rdata)
  );

  core_timer #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_core_timer (
    .clk       (clk),
    .rst       (rst),
    .rd_en_i   (tm_rd_en),
    .rd_addr_i (ar_addr),
    .rdata_o   (tm_rdata),
    .rvalid_o  (tm_rvalid)
  );

  assign ifu_rdata_o = map_rdata;
  assign lsu_rdata_o = tm_rvalid ? tm_rdata : map_rdata;  // timer answers bypass axi

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
  parameter int ADDR_W = 32,
  parameter int DEPTH  = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output logic [63:0]       rdata_o,
  output logic              rvalid_o,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [63:0]       wdata_i,
  input  logic [7:0]        wstrb_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic              bvalid_o
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [63:0]       mem [0:DEPTH-1];
  logic [15:0]       lfsr = 16'd63141;
  logic [63:0]       wword;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;
  logic              r_pend;
  logic              aw_done;
  logic              b_pend;
  int                ar_cnt;
  int                r_cnt;
  int                aw_cnt;
  int                w_cnt;
  int                b_cnt;
  int                j;

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++)
    begin
      val  = (val << 1) | lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // each 32-bit word holds its own byte offset, inverted copy on top
  initial
  begin
    logic [15:0] off;
    for (int i = 0; i < DEPTH; i++)
    begin
      off    = 16'(i * 8);
      mem[i] = {~(off + 16'd4), off + 16'd4, ~off, off};
    end
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_pend  = 1'b0;
      aw_done = 1'b0;
      b_pend  = 1'b0;
      take_bits(2, ar_cnt);
      take_bits(2, aw_cnt);
      take_bits(2, w_cnt);
    end
    else
    begin
      rvalid_o <= 1'b0;  // responses are single-cycle pulses
      bvalid_o <= 1'b0;
      if (r_pend)
      begin
        if (r_cnt == 0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[rd_addr[IDX_W+2:3]];
          r_pend = 1'b0;
        end
        else
          r_cnt--;
      end
      if (arvalid_i && arready_o)
      begin
        arready_o <= 1'b0;
        rd_addr = araddr_i;
        r_pend  = 1'b1;
        take_bits(2, r_cnt);
        take_bits(2, ar_cnt);
      end
      else if (arvalid_i && !r_pend)
      begin
        if (ar_cnt == 0)
          arready_o <= 1'b1;
        else
          ar_cnt--;
      end
      if (b_pend)
      begin
        if (b_cnt == 0)
        begin
          bvalid_o <= 1'b1;
          b_pend = 1'b0;
        end
        else
          b_cnt--;
      end
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        wr_addr = awaddr_i;
        aw_done = 1'b1;
        take_bits(2, aw_cnt);
      end
      else if (awvalid_i && !aw_done)
      begin
        if (aw_cnt == 0)
          awready_o <= 1'b1;
        else
          aw_cnt--;
      end
      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        wword = mem[wr_addr[IDX_W+2:3]];
        for (j = 0; j < 8; j++)
        begin
          if (wstrb_i[j])
            wword[8*j +: 8] = wdata_i[8*j +: 8];
        end
        mem[wr_addr[IDX_W+2:3]] = wword;
        aw_done = 1'b0;
        b_pend  = 1'b1;
        take_bits(2, b_cnt);
        take_bits(2, w_cnt);
      end
      else if (wvalid_i && aw_done)
      begin
        if (w_cnt == 0)
          wready_o <= 1'b1;
        else
          w_cnt--;
      end
    end
  end

endmodule

//--- tb_mem_bus.sv
`timescale 1ns/1ps

module tb_mem_bus;

  import bus_pkg::*;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int MAX_OPS  = 64;
  localparam int WAIT_MAX = 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        ifu_arvalid;
  logic [31:0] ifu_araddr;
  logic        ifu_rvalid;
  logic [31:0] ifu_rdata;
  logic        lsu_arvalid;
  logic [31:0] lsu_araddr;
  logic [7:0]  lsu_rstrb;
  logic        lsu_rvalid;
  logic [31:0] lsu_rdata;
  logic        lsu_awvalid;
  logic        lsu_wvalid;
  logic [31:0] lsu_awaddr;
  logic [31:0] lsu_wdata;
  logic [7:0]  lsu_wstrb;
  logic        lsu_wready;
  logic [1:0]  arburst;
  logic [2:0]  arsize;
  logic [7:0]  arlen;
  logic [3:0]  arid;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [63:0] rdata;
  logic        rvalid;
  logic        rready;
  logic [1:0]  awburst;
  logic [2:0]  awsize;
  logic [7:0]  awlen;
  logic [3:0]  awid;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic        wlast;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;

  logic [31:0] trace [0:6*MAX_OPS-1];
  logic [31:0] last_low = '0;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          other_errs = 0;

  // payload seen while each valid waits for its ready
  logic        ar_wait = 1'b0;
  logic        aw_wait = 1'b0;
  logic        w_wait  = 1'b0;
  logic [34:0] ar_q;
  logic [34:0] aw_q;
  logic [71:0] w_q;

  always #2 clk = ~clk;

  mem_bus_top #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .ifu_arvalid_i       (ifu_arvalid),
    .ifu_araddr_i        (ifu_araddr),
    .ifu_rvalid_o        (ifu_rvalid),
    .ifu_rdata_o         (ifu_rdata),
    .lsu_arvalid_i       (lsu_arvalid),
    .lsu_araddr_i        (lsu_araddr),
    .lsu_rstrb_i         (lsu_rstrb),
    .lsu_rvalid_o        (lsu_rvalid),
    .lsu_rdata_o         (lsu_rdata),
    .lsu_awvalid_i       (lsu_awvalid),
    .lsu_wvalid_i        (lsu_wvalid),
    .lsu_awaddr_i        (lsu_awaddr),
    .lsu_wdata_i         (lsu_wdata),
    .lsu_wstrb_i         (lsu_wstrb),
    .lsu_wready_o        (lsu_wready),
    .io_master_arburst_o (arburst),
    .io_master_arsize_o  (arsize),
    .io_master_arlen_o   (arlen),
    .io_master_arid_o    (arid),
    .io_master_araddr_o  (araddr),
    .io_master_arvalid_o (arvalid),
    .io_master_arready_i (arready),
    .io_master_rid_i     (4'd0),
    .io_master_rlast_i   (1'b1),
    .io_master_rdata_i   (rdata),
    .io_master_rresp_i   (2'b00),
    .io_master_rvalid_i  (rvalid),
    .io_master_rready_o  (rready),
    .io_master_awburst_o (awburst),
    .io_master_awsize_o  (awsize),
    .io_master_awlen_o   (awlen),
    .io_master_awid_o    (awid),
    .io_master_awaddr_o  (awaddr),
    .io_master_awvalid_o (awvalid),
    .io_master_awready_i (awready),
    .io_master_wlast_o   (wlast),
    .io_master_wdata_o   (wdata),
    .io_master_wstrb_o   (wstrb),
    .io_master_wvalid_o  (wvalid),
    .io_master_wready_i  (wready),
    .io_master_bid_i     (4'd0),
    .io_master_bresp_i   (2'b00),
    .io_master_bvalid_i  (bvalid),
    .io_master_bready_o  (bready)
  );

  tb_axi_mem #(
    .ADDR_W (ADDR_W)
  ) i_mem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rvalid_o  (rvalid),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bvalid_o  (bvalid)
  );

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for the %s at %0t", what, $time);
    other_errs++;
  endtask

  function automatic logic [31:0] strb_mask(input logic [7:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  // axsize is log2 of the byte count
  function automatic logic [31:0] size_for_strobe(input logic [7:0] strb);
    int bytes;
    int size;
    bytes = 0;
    size  = 0;
    for (int i = 0; i < 8; i++)
    begin
      bytes += strb[i];
    end
    while ((1 << size) < bytes)
    begin
      size++;
    end
    return size;
  endfunction

  task automatic fetch_word(input logic [31:0] addr, input logic [31:0] exp);
    int n;
    n = 0;
    ifu_arvalid <= 1'b1;
    ifu_araddr  <= addr;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (!ifu_rvalid && n < WAIT_MAX);
    if (ifu_rvalid)
      check_value("ifu_rdata_o", exp, ifu_rdata);
    else
      report_timeout("fetch response");
    ifu_arvalid <= 1'b0;
  endtask

  task automatic load_data(input logic [31:0] addr, input logic [7:0] strb,
                           input logic [31:0] exp);
    int n;
    n = 0;
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= addr;
    lsu_rstrb   <= strb;
    do
    begin
      @(posedge clk);
      n++;
      if (arvalid)
        check_value("io_master_arsize_o", size_for_strobe(strb), arsize);
    end
    while (!lsu_rvalid && n < WAIT_MAX);
    if (lsu_rvalid)
      check_value("lsu_rdata_o", exp, lsu_rdata & strb_mask(strb));
    else
      report_timeout("load response");
    lsu_arvalid <= 1'b0;
  endtask

  task automatic store_data(input logic [31:0] addr, input logic [31:0] data,
                            input logic [7:0] strb);
    int n;
    n = 0;
    lsu_awvalid <= 1'b1;
    lsu_wvalid  <= 1'b1;
    lsu_awaddr  <= addr;
    lsu_wdata   <= data;
    lsu_wstrb   <= strb;
    do
    begin
      @(posedge clk);
      n++;
      if (awvalid)
        check_value("io_master_awsize_o", size_for_strobe(strb), awsize);
    end
    while (!lsu_wready && n < WAIT_MAX);
    if (!lsu_wready)
      report_timeout("store response");
    lsu_awvalid <= 1'b0;
    lsu_wvalid  <= 1'b0;
  endtask

  // load and fetch raised in the same cycle and the load must finish first
  task automatic load_and_fetch(input logic [31:0] laddr, input logic [7:0] lstrb,
                                input logic [31:0] lexp, input logic [31:0] faddr,
                                input logic [31:0] fexp);
    int   n;
    logic l_done;
    logic f_done;
    n      = 0;
    l_done = 1'b0;
    f_done = 1'b0;
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= laddr;
    lsu_rstrb   <= lstrb;
    ifu_arvalid <= 1'b1;
    ifu_araddr  <= faddr;
    while (!(l_done && f_done) && n < WAIT_MAX)
    begin
      @(posedge clk);
      n++;
      if (ifu_rvalid && !f_done)
      begin
        assert (l_done)
        else
        begin
          $display("fetch completed before the waiting load at %0t", $time);
          other_errs++;
        end
        check_value("ifu_rdata_o", fexp, ifu_rdata);
        f_done = 1'b1;
        ifu_arvalid <= 1'b0;
      end
      if (lsu_rvalid && !l_done)
      begin
        check_value("lsu_rdata_o", lexp, lsu_rdata & strb_mask(lstrb));
        l_done = 1'b1;
        lsu_arvalid <= 1'b0;
      end
    end
    if (!(l_done && f_done))
      report_timeout("load and fetch responses");
    lsu_arvalid <= 1'b0;
    ifu_arvalid <= 1'b0;
  endtask

  task automatic read_timer(input logic [31:0] addr, input logic [31:0] exp);
    int n;
    n = 0;
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= addr;
    lsu_rstrb   <= 8'h0f;
    do
    begin
      @(posedge clk);
      n++;
      assert (!arvalid)
      else
      begin
        $display("AXI read address raised during a timer read at %0t", $time);
        proto_errs++;
      end
    end
    while (!lsu_rvalid && n < WAIT_MAX);
    if (lsu_rvalid)
    begin
      // first edge is the arbiter decision so the pulse shows up on the third
      assert (n == 3)
      else
      begin
        $display("timer answered %0d cycles after the request instead of 2", n - 1);
        other_errs++;
      end
      if (addr == RTC_ADDR_UP)
        check_value("lsu_rdata_o", exp, lsu_rdata);
      else
      begin
        assert (lsu_rdata > last_low)
        else
        begin
          $display("ERR %0t lsu_rdata_o exp > %h got %h", $time, last_low, lsu_rdata);
          value_errs++;
        end
        last_low = lsu_rdata;
      end
    end
    else
      report_timeout("timer response");
    lsu_arvalid <= 1'b0;
  endtask

  // axi valids hold with stable payload until ready
  always @(posedge clk)
  begin
    if (!rst)
    begin
      assert (!ar_wait || (arvalid && {arsize, araddr} == ar_q))
      else
      begin
        $display("arvalid dropped or its payload changed before arready at %0t", $time);
        proto_errs++;
      end
      assert (!aw_wait || (awvalid && {awsize, awaddr} == aw_q))
      else
      begin
        $display("awvalid dropped or its payload changed before awready at %0t", $time);
        proto_errs++;
      end
      assert (!w_wait || (wvalid && {wstrb, wdata} == w_q))
      else
      begin
        $display("wvalid dropped or its payload changed before wready at %0t", $time);
        proto_errs++;
      end
      if (arvalid)
      begin
        check_value("io_master_arburst_o", 32'd1, arburst);  // incr
        check_value("io_master_arlen_o", 32'd0, arlen);
        check_value("io_master_arid_o", 32'd0, arid);
      end
      if (awvalid)
      begin
        check_value("io_master_awburst_o", 32'd1, awburst);
        check_value("io_master_awlen_o", 32'd0, awlen);
        check_value("io_master_awid_o", 32'd0, awid);
      end
      if (wvalid)
        check_value("io_master_wlast_o", 32'd1, wlast);  // every beat is the last
      check_value("io_master_rready_o", 32'd1, rready);
      check_value("io_master_bready_o", 32'd1, bready);
    end
    ar_wait <= !rst && arvalid && !arready;
    aw_wait <= !rst && awvalid && !awready;
    w_wait  <= !rst && wvalid && !wready;
    ar_q    <= {arsize, araddr};
    aw_q    <= {awsize, awaddr};
    w_q     <= {wstrb, wdata};
  end

  initial
  begin
    int          idx;
    logic        done;
    logic [31:0] op;
    ifu_arvalid = 1'b0;
    ifu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_rstrb   = 8'h0f;
    lsu_awvalid = 1'b0;
    lsu_wvalid  = 1'b0;
    lsu_awaddr  = '0;
    lsu_wdata   = '0;
    lsu_wstrb   = 8'h0f;
    $readmemh("mem_bus_trace.txt", trace);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idx  = 0;
    done = 1'b0;
    if ($isunknown(trace[0]) || trace[0] == 32'd0)
    begin
      $display("no operations could be read from the trace file");
      other_errs++;
    end
    while (!done && idx < MAX_OPS)
    begin
      op = trace[6*idx];
      if ($isunknown(op) || op == 32'd0 || other_errs != 0)
        done = 1'b1;
      else
      begin
        @(posedge clk);
        case (op)
          32'd1: fetch_word(trace[6*idx+1], trace[6*idx+4]);
          32'd2: load_data(trace[6*idx+1], trace[6*idx+3][7:0], trace[6*idx+4]);
          32'd3: store_data(trace[6*idx+1], trace[6*idx+2], trace[6*idx+3][7:0]);
          32'd4: load_and_fetch(trace[6*idx+1], trace[6*idx+3][7:0], trace[6*idx+4],
                                trace[6*idx+5], trace[6*idx+2]);
          32'd5: read_timer(trace[6*idx+1], trace[6*idx+4]);
          default:
          begin
            $display("unknown operation %0d on trace line %0d", op, idx);
            other_errs++;
          end
        endcase
        idx++;
      end
    end
    repeat (4) @(posedge clk);
    $display("errors: value %0d, protocol %0d, other %0d", value_errs, proto_errs, other_errs);
    if (value_errs == 0 && proto_errs == 0 && other_errs == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- mem_bus_trace.txt
// columns (hex): op addr data strb expect aux
// op 1 fetch, 2 load, 3 store, 4 load+fetch (aux fetch addr, data fetch expect), 5 timer, 0 end
1 80000000 00000000 0f ffff0000 00000000
1 80000004 00000000 0f fffb0004 00000000
1 80000100 00000000 0f feff0100 00000000
1 8000010c 00000000 0f fef3010c 00000000
2 80000022 00000000 01 000000df 00000000
2 80000023 00000000 01 000000ff 00000000
2 80000026 00000000 03 0000ffdb 00000000
2 8000002e 00000000 01 000000d3 00000000
2 80000060 00000000 0f ff9f0060 00000000
3 80000041 000000a5 01 00000000 00000000
2 80000040 00000000 0f ffbfa540 00000000
2 80000044 00000000 0f ffbb0044 00000000
3 80000046 00001234 03 00000000 00000000
2 80000044 00000000 0f 12340044 00000000
2 80000040 00000000 0f ffbfa540 00000000
3 80000048 deadbeef 0f 00000000 00000000
2 80000048 00000000 0f deadbeef 00000000
3 8000004f 0000007e 01 00000000 00000000
2 8000004c 00000000 0f 7eb3004c 00000000
2 8000004f 00000000 01 0000007e 00000000
4 80000022 feff0100 01 000000df 80000100
4 80000048 fffb0004 0f deadbeef 80000004
5 0200bffc 00000000 0f 00000000 00000000
5 0200bff8 00000000 0f 00000000 00000000
5 0200bff8 00000000 0f 00000000 00000000
1 80000200 00000000 0f fdff0200 00000000
0 00000000 00000000 00 00000000 00000000

//--- filelist.f
bus_pkg.sv
core_timer.sv
lane_mapper.sv
bus_arbiter.sv
mem_bus_top.sv
tb_axi_mem.sv
tb_mem_bus.sv

//--- Bender.yml
package:
  name: mem_bus

sources:
  - bus_pkg.sv
  - core_timer.sv
  - lane_mapper.sv
  - bus_arbiter.sv
  - mem_bus_top.sv
  - target: simulation
    files:
      - tb_axi_mem.sv
      - tb_mem_bus.sv
